/* common/bpu_cfg_pkg.sv */
package bpu_cfg_pkg;

    localparam int xlen = 32;
    localparam int hist_len = 16;            // global history depth

    // bimodal base table, indexed by pc[9:1]
    localparam int bimodal_entries = 512;

    // tagged tables
    localparam int tage_entries = 256;       // index is pc[7:0] ^ history slice
    localparam int tag_width = 10;           // pc[17:8] ^ history
    localparam int partial_tag_bits = 6;     // upper tag bits compared on lookup

    // target buffer, indexed by pc[9:2]
    localparam int btb_entries = 256;
    localparam int btb_tag_width = 22;       // pc[31:10]

    // return stack
    localparam int ras_depth = 64;
    localparam int ras_ptr_width = 7;        // one extra bit so a full stack fits

    // rv32 opcodes used by the classifier
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;

    // link registers
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

endpackage

/* common/bpu_types_pkg.sv */
package bpu_types_pkg;

    typedef logic [bpu_cfg_pkg::xlen-1:0] addr_t;
    typedef logic [bpu_cfg_pkg::hist_len-1:0] hist_t;
    typedef logic [1:0] ctr_t;               // 2-bit saturating counter

    // which table gave the direction
    typedef enum logic [1:0] {
        prov_bimodal,
        prov_short,
        prov_long
    } provider_e;

    typedef enum logic [2:0] {
        kind_none,
        kind_branch,
        kind_jal,
        kind_jalr,
        kind_ret
    } inst_kind_e;

    typedef struct packed {
        addr_t pc;
        addr_t inst;
    } fetch_req_t;

    typedef struct packed {
        logic      is_cti;
        logic      taken;
        addr_t     next_pc;
        provider_e provider;
        hist_t     hist;        // history snapshot used for this lookup
    } prediction_t;

    // resolved control transfer from execute
    typedef struct packed {
        logic      valid;
        logic      taken;
        logic      mispredict;
        logic      is_ret;
        addr_t     pc;
        addr_t     target;
        hist_t     hist;
        provider_e provider;
    } ex_update_t;

    typedef struct packed {
        logic      taken;
        provider_e provider;
    } dir_lookup_t;

    typedef struct packed {
        logic  hit;
        addr_t target;
    } btb_lookup_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } ras_lookup_t;

endpackage

/* tage/tage_table.sv */
`timescale 1ns/1ps

module tage_table #(
    parameter int hist_lo = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  bpu_types_pkg::addr_t      lookup_pc_i,
    input  bpu_types_pkg::hist_t      lookup_hist_i,
    input  bpu_types_pkg::ex_update_t upd_i,
    input  logic                      alloc_i,
    output logic                      hit_o,
    output bpu_types_pkg::ctr_t       ctr_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int idx_w = $clog2(tage_entries);
    localparam int cmp_lo = tag_width - partial_tag_bits;
    localparam provider_e own_prov = (hist_lo == 0) ? prov_short : prov_long;

    logic                 valid_q [tage_entries];
    logic [tag_width-1:0] tag_q [tage_entries];
    ctr_t                 ctr_q [tage_entries];

    logic [idx_w-1:0]     look_idx;
    logic [idx_w-1:0]     upd_idx;
    logic [tag_width-1:0] look_tag;
    logic [tag_width-1:0] upd_tag;

    function automatic logic [idx_w-1:0] hash_idx(addr_t pc, hist_t hist);
        hash_idx = pc[idx_w-1:0] ^ hist[hist_lo +: idx_w];
    endfunction

    // tag mixes in the history bits the index leaves out
    function automatic logic [tag_width-1:0] hash_tag(addr_t pc, hist_t hist);
        logic [tag_width-1:0] mix;
        if (hist_lo == 0) begin
            mix = hist[hist_len-1 -: tag_width];
        end else begin
            mix = {{(tag_width-idx_w){1'b0}}, hist[idx_w-1:0]};
        end
        hash_tag = pc[idx_w +: tag_width] ^ mix;
    endfunction

    assign look_idx = hash_idx(lookup_pc_i, lookup_hist_i);
    assign look_tag = hash_tag(lookup_pc_i, lookup_hist_i);
    assign upd_idx = hash_idx(upd_i.pc, upd_i.hist);    // train on the lookup-time history
    assign upd_tag = hash_tag(upd_i.pc, upd_i.hist);

    assign hit_o = valid_q[look_idx]
                && (tag_q[look_idx][tag_width-1:cmp_lo] == look_tag[tag_width-1:cmp_lo]);
    assign ctr_o = ctr_q[look_idx];

    initial begin
        for (int i = 0; i < tage_entries; i++) begin
            tag_q[i] = '0;
            ctr_q[i] = 2'b01;                            // weakly not taken
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tage_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_i.valid && alloc_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (upd_i.valid) begin
            if (alloc_i) begin
                tag_q[upd_idx] <= upd_tag;
                ctr_q[upd_idx] <= upd_i.taken ? 2'b10 : 2'b01;
            end else if (upd_i.provider == own_prov) begin
                if (upd_i.mispredict) begin
                    ctr_q[upd_idx] <= upd_i.taken ? 2'b11 : 2'b00;  // jump to strong
                end else if (upd_i.taken && ctr_q[upd_idx] != 2'b11) begin
                    ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'b01;
                end else if (!upd_i.taken && ctr_q[upd_idx] != 2'b00) begin
                    ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'b01;
                end
            end
        end
    end

    // the predictor only allocates after a bimodal miss
    a_no_alloc_over_provider: assert property (
        @(posedge clk) disable iff (rst)
        (upd_i.valid && alloc_i) |-> (upd_i.provider != own_prov)
    );

endmodule

/* tage/tage_predictor.sv */
`timescale 1ns/1ps

module tage_predictor (
    input  logic                       clk,
    input  logic                       rst,
    input  bpu_types_pkg::addr_t       pc_i,
    input  bpu_types_pkg::ex_update_t  upd_i,
    output bpu_types_pkg::dir_lookup_t dir_o,
    output bpu_types_pkg::hist_t       hist_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int bm_idx_w = $clog2(bimodal_entries);
    localparam int tage_idx_w = $clog2(tage_entries);
    localparam int long_hist_lo = hist_len - tage_idx_w;

    hist_t hist_q;
    ctr_t  bimodal_q [bimodal_entries];

    // copy of the long table's tags, only needed to pick the allocation target
    logic [tag_width-1:0] long_tag_q [tage_entries];

    logic                  short_hit;
    logic                  long_hit;
    ctr_t                  short_ctr;
    ctr_t                  long_ctr;
    logic [bm_idx_w-1:0]   bm_look_idx;
    logic [bm_idx_w-1:0]   bm_upd_idx;
    ctr_t                  bm_upd_ctr;
    logic [tage_idx_w-1:0] long_upd_idx;
    logic [tag_width-1:0]  long_upd_tag;
    logic                  bimodal_miss;
    logic                  alloc_long;
    logic                  alloc_short;

    tage_table #(.hist_lo(0)) u_short (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc_i   (pc_i),
        .lookup_hist_i (hist_q),
        .upd_i         (upd_i),
        .alloc_i       (alloc_short),
        .hit_o         (short_hit),
        .ctr_o         (short_ctr)
    );

    tage_table #(.hist_lo(long_hist_lo)) u_long (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc_i   (pc_i),
        .lookup_hist_i (hist_q),
        .upd_i         (upd_i),
        .alloc_i       (alloc_long),
        .hit_o         (long_hit),
        .ctr_o         (long_ctr)
    );

    assign bm_look_idx = pc_i[bm_idx_w:1];
    assign bm_upd_idx = upd_i.pc[bm_idx_w:1];
    assign bm_upd_ctr = bimodal_q[bm_upd_idx];

    // same hash as the long table uses
    assign long_upd_idx = upd_i.pc[tage_idx_w-1:0] ^ upd_i.hist[hist_len-1 -: tage_idx_w];
    assign long_upd_tag = upd_i.pc[tage_idx_w +: tag_width]
                        ^ {{(tag_width-tage_idx_w){1'b0}}, upd_i.hist[tage_idx_w-1:0]};

    assign bimodal_miss = upd_i.valid && upd_i.mispredict && (upd_i.provider == prov_bimodal);
    assign alloc_long = bimodal_miss && (long_tag_q[long_upd_idx] != long_upd_tag);
    assign alloc_short = bimodal_miss && !alloc_long;   // long slot already holds this tag

    // longest matching history wins
    always_comb begin
        if (long_hit) begin
            dir_o.provider = prov_long;
            dir_o.taken = long_ctr[1];
        end else if (short_hit) begin
            dir_o.provider = prov_short;
            dir_o.taken = short_ctr[1];
        end else begin
            dir_o.provider = prov_bimodal;
            dir_o.taken = bimodal_q[bm_look_idx][1];
        end
    end

    initial begin
        for (int i = 0; i < bimodal_entries; i++) begin
            bimodal_q[i] = 2'b01;
        end
        for (int i = 0; i < tage_entries; i++) begin
            long_tag_q[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (upd_i.valid) begin
            if (upd_i.taken && bm_upd_ctr != 2'b11) begin
                bimodal_q[bm_upd_idx] <= bm_upd_ctr + 2'b01;
            end else if (!upd_i.taken && bm_upd_ctr != 2'b00) begin
                bimodal_q[bm_upd_idx] <= bm_upd_ctr - 2'b01;
            end
        end
        if (alloc_long) begin
            long_tag_q[long_upd_idx] <= long_upd_tag;
        end
    end

    // newest outcome enters at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (upd_i.valid) begin
            hist_q <= {hist_q[hist_len-2:0], upd_i.taken};
        end
    end

    assign hist_o = hist_q;

endmodule

/* hdl/btb.sv */
`timescale 1ns/1ps

module btb (
    input  logic                       clk,
    input  logic                       rst,
    input  bpu_types_pkg::addr_t       pc_i,
    input  bpu_types_pkg::ex_update_t  upd_i,
    output bpu_types_pkg::btb_lookup_t look_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int idx_w = $clog2(btb_entries);

    logic                     valid_q [btb_entries];
    logic [btb_tag_width-1:0] tag_q [btb_entries];
    addr_t                    target_q [btb_entries];

    logic [idx_w-1:0]         look_idx;
    logic [idx_w-1:0]         upd_idx;
    logic [btb_tag_width-1:0] look_tag;
    logic [btb_tag_width-1:0] upd_tag;
    logic                     fill;

    assign look_idx = pc_i[idx_w+1:2];                  // word aligned
    assign look_tag = pc_i[xlen-1 -: btb_tag_width];
    assign upd_idx = upd_i.pc[idx_w+1:2];
    assign upd_tag = upd_i.pc[xlen-1 -: btb_tag_width];
    assign fill = upd_i.valid && upd_i.taken;

    // full tag compare, no aliasing between pages
    assign look_o.hit = valid_q[look_idx] && (tag_q[look_idx] == look_tag);
    assign look_o.target = target_q[look_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[upd_idx] <= upd_tag;
            target_q[upd_idx] <= upd_i.target;          // last taken target wins
        end
    end

endmodule

/* hdl/ras.sv */
`timescale 1ns/1ps

module ras (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push_i,
    input  bpu_types_pkg::addr_t       push_addr_i,
    input  bpu_types_pkg::ex_update_t  upd_i,
    input  logic                       stall_i,
    output bpu_types_pkg::ras_lookup_t look_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    addr_t                    stack_q [ras_depth];
    logic [ras_ptr_width-1:0] ptr_q;                    // next free slot
    logic [ras_ptr_width-1:0] top_ptr;
    logic [ras_ptr_width-1:0] ptr_popped;
    logic                     do_pop;
    logic                     do_push;

    assign do_pop = upd_i.valid && upd_i.taken && upd_i.is_ret && !stall_i && (ptr_q != '0);
    assign ptr_popped = do_pop ? ptr_q - 1'b1 : ptr_q;

    // push lands on the slot left after any pop this cycle
    assign do_push = push_i && !stall_i && (ptr_popped < ras_ptr_width'(ras_depth));

    assign top_ptr = ptr_q - 1'b1;

    always_comb begin
        if (push_i) begin
            look_o.valid = 1'b1;
            look_o.target = push_addr_i;                // call and return in flight together
        end else if (ptr_q != '0) begin
            look_o.valid = 1'b1;
            look_o.target = stack_q[top_ptr[ras_ptr_width-2:0]];
        end else begin
            look_o.valid = 1'b0;
            look_o.target = push_addr_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (do_push) begin
            ptr_q <= ptr_popped + 1'b1;
        end else begin
            ptr_q <= ptr_popped;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[ptr_popped[ras_ptr_width-2:0]] <= push_addr_i;
        end
    end

    a_ptr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        ptr_q <= ras_ptr_width'(ras_depth)
    );

    // an empty stack can only grow
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (ptr_q == '0) |=> (ptr_q <= ras_ptr_width'(1))
    );

endmodule

/* hdl/next_pc_select.sv */
`timescale 1ns/1ps

module next_pc_select (
    input  bpu_types_pkg::fetch_req_t  req_i,
    input  bpu_types_pkg::dir_lookup_t dir_i,
    input  bpu_types_pkg::btb_lookup_t btb_i,
    input  bpu_types_pkg::ras_lookup_t ras_i,
    input  bpu_types_pkg::hist_t       hist_i,
    output bpu_types_pkg::prediction_t pred_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] imm_i;
    logic        is_ret;
    addr_t       pc_plus4;
    addr_t       j_target;
    addr_t       b_target;
    inst_kind_e  kind;

    assign opcode = req_i.inst[6:0];
    assign rd = req_i.inst[11:7];
    assign rs1 = req_i.inst[19:15];
    assign imm_i = req_i.inst[31:20];

    // jalr x0, 0(ra) or jalr x0, 0(t0)
    assign is_ret = (rd == 5'd0) && ((rs1 == reg_ra) || (rs1 == reg_t0)) && (imm_i == 12'd0);

    assign pc_plus4 = req_i.pc + 32'd4;
    assign j_target = req_i.pc + {{12{req_i.inst[31]}}, req_i.inst[19:12], req_i.inst[20],
                                  req_i.inst[30:21], 1'b0};
    assign b_target = req_i.pc + {{20{req_i.inst[31]}}, req_i.inst[7], req_i.inst[30:25],
                                  req_i.inst[11:8], 1'b0};

    always_comb begin
        case (opcode)
            op_branch: kind = kind_branch;
            op_jal:    kind = kind_jal;
            op_jalr:   kind = is_ret ? kind_ret : kind_jalr;
            default:   kind = kind_none;
        endcase
    end

    always_comb begin
        pred_o.is_cti = (kind != kind_none);
        pred_o.taken = 1'b0;
        pred_o.next_pc = pc_plus4;
        pred_o.provider = prov_bimodal;
        pred_o.hist = hist_i;
        case (kind)
            kind_ret: begin
                if (ras_i.valid) begin                  // empty stack falls through
                    pred_o.taken = 1'b1;
                    pred_o.next_pc = ras_i.target;
                end
            end
            kind_jal: begin
                pred_o.taken = 1'b1;
                pred_o.next_pc = btb_i.hit ? btb_i.target : j_target;
            end
            kind_branch: begin
                pred_o.taken = dir_i.taken;
                pred_o.provider = dir_i.provider;
                if (dir_i.taken) begin
                    pred_o.next_pc = btb_i.hit ? btb_i.target : b_target;
                end
            end
            default: begin
                pred_o.taken = 1'b0;                    // indirect jumps stay sequential
            end
        endcase
    end

endmodule

/* hdl/bpu_top.sv */
`timescale 1ns/1ps

module bpu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  bpu_types_pkg::fetch_req_t  req_i,
    input  bpu_types_pkg::ex_update_t  upd_i,
    input  logic                       id_push_i,
    input  bpu_types_pkg::addr_t       id_push_addr_i,
    input  logic                       stall_i,
    output bpu_types_pkg::prediction_t pred_o,
    output bpu_types_pkg::hist_t       history_o
);
    import bpu_types_pkg::*;

    dir_lookup_t dir_look;
    btb_lookup_t btb_look;
    ras_lookup_t ras_look;
    hist_t       hist;

    // direction and global history
    tage_predictor u_tage (
        .clk    (clk),
        .rst    (rst),
        .pc_i   (req_i.pc),
        .upd_i  (upd_i),
        .dir_o  (dir_look),
        .hist_o (hist)
    );

    btb u_btb (
        .clk    (clk),
        .rst    (rst),
        .pc_i   (req_i.pc),
        .upd_i  (upd_i),
        .look_o (btb_look)
    );

    ras u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (id_push_i),
        .push_addr_i (id_push_addr_i),
        .upd_i       (upd_i),
        .stall_i     (stall_i),
        .look_o      (ras_look)
    );

    next_pc_select u_sel (
        .req_i  (req_i),
        .dir_i  (dir_look),
        .btb_i  (btb_look),
        .ras_i  (ras_look),
        .hist_i (hist),
        .pred_o (pred_o)
    );

    assign history_o = hist;

endmodule

/* verification/bpu_tb_vectors.svh */
// one row per test, applied in order
// columns: rnd_pc, pc, inst, update kind, addr (update target or pushed address),
//          {push, stall}, expected {is_cti, taken}, expected provider, expected next_pc,
//          expected history

typedef enum logic [2:0] {
    upd_none,
    upd_taken,
    upd_not_taken,
    upd_miss,           // taken, mispredicted by the bimodal table
    upd_ret             // taken return
} upd_kind_e;

typedef struct packed {
    logic       rnd_pc;             // pc from $random, next_pc is then pc+4
    addr_t      pc;
    addr_t      inst;
    upd_kind_e  upd;
    addr_t      addr;
    logic [1:0] push_stall;
    logic [1:0] exp_cti_taken;
    provider_e  exp_prov;
    addr_t      exp_next;
    hist_t      exp_hist;
} row_t;

localparam addr_t i_nop = 32'h00000013;
localparam addr_t i_add = 32'h00b50533;
localparam addr_t i_lw = 32'h0002a083;
localparam addr_t i_lui = 32'h123450b7;
localparam addr_t i_jal = 32'h1000006f;        // jal x0, +0x100
localparam addr_t i_beq = 32'h00000863;        // beq x0, x0, +16
localparam addr_t i_jalr = 32'h000100e7;       // jalr x1, 0(x2)
localparam addr_t i_ret = 32'h00008067;        // jalr x0, 0(x1)
localparam addr_t i_ret_t0 = 32'h00028067;     // jalr x0, 0(x5)

localparam int n_rows = 35;

string names [n_rows] = '{
    "rand_nop", "rand_add", "rand_load", "rand_lui",
    "jal_no_btb", "branch_fresh", "jalr_indirect", "train_taken_miss",
    "btb_alias_jal", "btb_hit_jal", "ras_empty_ret", "ras_push_a",
    "ras_push_b", "ras_top_b", "ras_pop_b", "ras_stall_pop",
    "ras_stall_push", "ras_after_stall", "ras_pop_a", "ras_pop_empty",
    "ras_push_d", "ras_top_d", "hist_00", "hist_01",
    "hist_02", "hist_03", "hist_04", "hist_05",
    "hist_06", "hist_07", "hist_08", "hist_09",
    "hist_10", "hist_11", "hist_hold"
};

row_t table_rows [n_rows] = '{
    '{1'b1, 32'h0, i_nop, upd_none, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h0, 16'h0000},
    '{1'b1, 32'h0, i_add, upd_none, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h0, 16'h0000},
    '{1'b1, 32'h0, i_lw, upd_none, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h0, 16'h0000},
    '{1'b1, 32'h0, i_lui, upd_none, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h0, 16'h0000},
    '{1'b0, 32'h1000, i_jal, upd_none, 32'h0, 2'b00, 2'b11, prov_bimodal, 32'h1100, 16'h0000},
    '{1'b0, 32'h2000, i_beq, upd_none, 32'h0, 2'b00, 2'b10, prov_bimodal, 32'h2004, 16'h0000},
    '{1'b0, 32'h3000, i_jalr, upd_none, 32'h0, 2'b00, 2'b10, prov_bimodal, 32'h3004, 16'h0000},
    '{1'b0, 32'h12340, i_beq, upd_miss, 32'h45670, 2'b00, 2'b11, prov_long, 32'h45670,
      16'h0001},
    '{1'b0, 32'h12740, i_jal, upd_none, 32'h0, 2'b00, 2'b11, prov_bimodal, 32'h12840,
      16'h0001},
    '{1'b0, 32'h12340, i_jal, upd_none, 32'h0, 2'b00, 2'b11, prov_bimodal, 32'h45670,
      16'h0001},
    '{1'b0, 32'h4000, i_ret, upd_none, 32'h0, 2'b00, 2'b10, prov_bimodal, 32'h4004, 16'h0001},
    '{1'b0, 32'h4000, i_ret, upd_none, 32'h5004, 2'b10, 2'b11, prov_bimodal, 32'h5004,
      16'h0001},
    '{1'b0, 32'h4000, i_ret, upd_none, 32'h6008, 2'b10, 2'b11, prov_bimodal, 32'h6008,
      16'h0001},
    '{1'b0, 32'h4000, i_ret, upd_none, 32'h0, 2'b00, 2'b11, prov_bimodal, 32'h6008, 16'h0001},
    '{1'b0, 32'h4000, i_ret, upd_ret, 32'h6008, 2'b00, 2'b11, prov_bimodal, 32'h5004,
      16'h0003},
    '{1'b0, 32'h4000, i_ret, upd_ret, 32'h5004, 2'b01, 2'b11, prov_bimodal, 32'h5004,
      16'h0007},
    '{1'b0, 32'h4000, i_ret, upd_none, 32'h7000, 2'b11, 2'b11, prov_bimodal, 32'h7000,
      16'h0007},
    '{1'b0, 32'h4000, i_ret, upd_none, 32'h0, 2'b00, 2'b11, prov_bimodal, 32'h5004, 16'h0007},
    '{1'b0, 32'h4000, i_ret, upd_ret, 32'h5004, 2'b00, 2'b10, prov_bimodal, 32'h4004,
      16'h000f},
    '{1'b0, 32'h4100, i_ret_t0, upd_ret, 32'h5004, 2'b00, 2'b10, prov_bimodal, 32'h4104,
      16'h001f},
    '{1'b0, 32'h4000, i_ret, upd_none, 32'h8010, 2'b10, 2'b11, prov_bimodal, 32'h8010,
      16'h001f},
    '{1'b0, 32'h4000, i_ret, upd_none, 32'h0, 2'b00, 2'b11, prov_bimodal, 32'h8010, 16'h001f},
    '{1'b0, 32'h9000, i_nop, upd_not_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9004,
      16'h003e},
    '{1'b0, 32'h9004, i_nop, upd_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9008, 16'h007d},
    '{1'b0, 32'h9008, i_nop, upd_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h900c, 16'h00fb},
    '{1'b0, 32'h900c, i_nop, upd_not_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9010,
      16'h01f6},
    '{1'b0, 32'h9010, i_nop, upd_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9014, 16'h03ed},
    '{1'b0, 32'h9014, i_nop, upd_not_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9018,
      16'h07da},
    '{1'b0, 32'h9018, i_nop, upd_not_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h901c,
      16'h0fb4},
    '{1'b0, 32'h901c, i_nop, upd_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9020, 16'h1f69},
    '{1'b0, 32'h9020, i_nop, upd_not_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9024,
      16'h3ed2},
    '{1'b0, 32'h9024, i_nop, upd_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9028, 16'h7da5},
    '{1'b0, 32'h9028, i_nop, upd_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h902c, 16'hfb4b},
    '{1'b0, 32'h902c, i_nop, upd_taken, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9030, 16'hf697},
    '{1'b0, 32'h9030, i_nop, upd_none, 32'h0, 2'b00, 2'b00, prov_bimodal, 32'h9034, 16'hf697}
};

/* verification/bpu_tb.sv */
`timescale 1ns/1ps

module bpu_tb;
    import bpu_types_pkg::*;

    `include "bpu_tb_vectors.svh"

    localparam int reset_cycles = 16;
    localparam int watchdog_ns = (reset_cycles + n_rows) * 4 + 100;

    logic        clk;
    logic        rst;
    fetch_req_t  req;
    ex_update_t  upd;
    logic        push;
    addr_t       push_addr;
    logic        stall;
    prediction_t pred;
    hist_t       history;

    integer seed = 29;
    int     row_errors;

    bpu_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req),
        .upd_i          (upd),
        .id_push_i      (push),
        .id_push_addr_i (push_addr),
        .stall_i        (stall),
        .pred_o         (pred),
        .history_o      (history)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    // turn one table row into DUT inputs
    task automatic drive_row(input row_t r, input addr_t pc, input hist_t snap);
        req.pc = pc;
        req.inst = r.inst;
        upd.valid = (r.upd != upd_none);
        upd.taken = (r.upd == upd_taken) || (r.upd == upd_miss) || (r.upd == upd_ret);
        upd.mispredict = (r.upd == upd_miss);
        upd.is_ret = (r.upd == upd_ret);
        upd.pc = pc;
        upd.target = r.addr;
        upd.hist = snap;                        // history seen at lookup time
        upd.provider = prov_bimodal;
        push = r.push_stall[1];
        push_addr = r.addr;
        stall = r.push_stall[0];
    endtask

    task automatic compare_field(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test, field, expected, actual);
            row_errors++;
        end
    endtask

    initial begin
        int    failed;
        row_t  r;
        addr_t pc;
        addr_t exp_next;
        hist_t prev_hist;

        failed = 0;
        prev_hist = '0;
        rst = 1'b1;
        req = '0;
        upd = '0;
        push = 1'b0;
        push_addr = '0;
        stall = 1'b0;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            r = table_rows[i];
            @(negedge clk);
            pc = r.pc;
            exp_next = r.exp_next;
            if (r.rnd_pc) begin
                pc = $random(seed);
                pc[1:0] = 2'b00;
                exp_next = pc + 32'd4;          // sequential fetch
            end
            drive_row(r, pc, prev_hist);

            // update lands on this edge, sample a little later
            @(posedge clk);
            #1;
            row_errors = 0;
            compare_field(names[i], "is_cti", 32'(r.exp_cti_taken[1]), 32'(pred.is_cti));
            compare_field(names[i], "taken", 32'(r.exp_cti_taken[0]), 32'(pred.taken));
            compare_field(names[i], "provider", 32'(r.exp_prov), 32'(pred.provider));
            compare_field(names[i], "next_pc", exp_next, pred.next_pc);
            compare_field(names[i], "pred_hist", 32'(r.exp_hist), 32'(pred.hist));
            compare_field(names[i], "history", 32'(r.exp_hist), 32'(history));

            if (row_errors == 0) begin
                $display("test %0d %s passed", i, names[i]);
            end else begin
                $display("test %0d %s had %0d mismatches", i, names[i], row_errors);
                failed++;
            end
            prev_hist = r.exp_hist;
        end

        $display("%0d tests, %0d passed, %0d failed", n_rows, n_rows - failed, failed);
        if (failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns before all tests finished", watchdog_ns);
        $display("Something failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+verification
common/bpu_cfg_pkg.sv
common/bpu_types_pkg.sv
tage/tage_table.sv
tage/tage_predictor.sv
hdl/btb.sv
hdl/ras.sv
hdl/next_pc_select.sv
hdl/bpu_top.sv
verification/bpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module bpu_tb -f files.f -Mdir obj_dir -o bpu_sim

status=0
./obj_dir/bpu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
